// ==== common/stat_cfg_pkg.sv ====
// statistics aggregation sizes shared by the arbiter, the accumulator and the top level

package stat_cfg_pkg;

    // ============================
    // counter addressing
    // ============================

    // one counter index, as carried with every increment
    localparam int STAT_ID_W = 11;

    // number of counters held by the accumulator memory
    localparam int STAT_DEPTH = 2048;

    // ============================
    // data widths
    // ============================

    // one increment message carries up to this many bits of count
    localparam int STAT_INC_W = 16;

    // counters wrap modulo 2^STAT_COUNT_W
    localparam int STAT_COUNT_W = 64;

    // ============================
    // sources
    // ============================

    localparam int DEF_PORT_CNT = 9;

endpackage

// ==== common/stat_types_pkg.sv ====
// message, operation and mode types passed between the statistics pipeline stages

package stat_types_pkg;

    import stat_cfg_pkg::*;

    // ============================
    // increment stream
    // ============================

    // one increment message on a valid/ready stream
    typedef struct packed {
        logic                  valid;
        logic [STAT_ID_W-1:0]  id;
        logic [STAT_INC_W-1:0] inc;
    } stat_inc_t;

    // ============================
    // accumulator internals
    // ============================

    // memory operation issued in one cycle
    typedef enum logic [1:0] {
        OP_IDLE   = 2'd0,
        OP_UPDATE = 2'd1,
        OP_READ   = 2'd2,
        OP_CLEAR  = 2'd3
    } stat_op_e;

    // operation travelling down the update pipeline
    typedef struct packed {
        stat_op_e              op;
        logic [STAT_ID_W-1:0]  id;
        logic [STAT_INC_W-1:0] inc;
    } stat_op_t;

    // memory sweep after reset, then normal operation
    typedef enum logic {
        ST_CLEAR = 1'b0,
        ST_RUN   = 1'b1
    } accum_state_e;

endpackage

// ==== stat/stat_arb_mux.sv ====
// round-robin arbiter that merges the increment sources into one registered stream

`timescale 1ns/1ps

module stat_arb_mux
    import stat_cfg_pkg::*;
    import stat_types_pkg::*;
#(
    parameter int PORT_CNT = DEF_PORT_CNT
)
(
    input  logic                clk_125mhz,
    input  logic                rst_n_i,

    // source streams
    input  stat_inc_t           s_stat_i [PORT_CNT],
    output logic [PORT_CNT-1:0] s_stat_ready_o,

    // merged stream towards the accumulator
    output stat_inc_t           m_stat_o,
    input  logic                m_ready_i
);

    localparam int IDX_W = (PORT_CNT > 1) ? $clog2(PORT_CNT) : 1;

    // last granted source, the search starts just after it
    logic [IDX_W-1:0] last_q;
    logic [IDX_W-1:0] grant_idx;
    logic             grant_vld;

    // registered output stage
    stat_inc_t        out_q;

    // ============================
    // grant selection
    // ============================

    always_comb begin
        int idx;

        grant_vld = 1'b0;
        grant_idx = last_q;
        for (int k = 1; k <= PORT_CNT; k++) begin
            idx = (int'(last_q) + k) % PORT_CNT;
            if (!grant_vld && s_stat_i[idx].valid) begin
                grant_vld = 1'b1;
                grant_idx = IDX_W'(idx);
            end
        end
    end

    // the output stage advances only in cycles where the accumulator takes
    // its content, so a full stage is emptied while the next message loads
    // and nothing is taken from a source during the clear sweep
    always_comb begin
        s_stat_ready_o = '0;
        if (m_ready_i && grant_vld) begin
            s_stat_ready_o[grant_idx] = 1'b1;
        end
    end

    // ============================
    // output register
    // ============================

    always_ff @(posedge clk_125mhz or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_q  <= '0;
            // source 0 gets the first turn after reset
            last_q <= IDX_W'(PORT_CNT - 1);
        end else if (m_ready_i) begin
            out_q.valid <= grant_vld;
            out_q.id    <= s_stat_i[grant_idx].id;
            out_q.inc   <= s_stat_i[grant_idx].inc;
            if (grant_vld) begin
                last_q <= grant_idx;
            end
        end
    end

    assign m_stat_o = out_q;

endmodule

// ==== stat/stat_accum.sv ====
// counter memory with clear sweep, two-stage update pipeline, forwarding and host read port

`timescale 1ns/1ps

module stat_accum
    import stat_cfg_pkg::*;
    import stat_types_pkg::*;
(
    input  logic                    clk_125mhz,
    input  logic                    rst_n_i,

    // increment stream from the arbiter
    input  stat_inc_t               s_stat_i,
    output logic                    s_ready_o,

    // host read port
    input  logic                    rd_req_i,
    input  logic [STAT_ID_W-1:0]    rd_id_i,
    output logic                    rd_valid_o,
    output logic [STAT_COUNT_W-1:0] rd_data_o,

    // high while the memory is being cleared
    output logic                    init_busy_o
);

    // result written back in the previous cycle, kept for forwarding
    typedef struct packed {
        logic                    vld;
        logic [STAT_ID_W-1:0]    id;
        logic [STAT_COUNT_W-1:0] data;
    } wb_t;

    accum_state_e            state_q;
    logic [STAT_ID_W-1:0]    clr_cnt_q;

    // operation issued this cycle and the two pipeline stages behind it
    stat_op_t                issue_op;
    stat_op_t                op1_q;
    stat_op_t                op2_q;

    logic [STAT_COUNT_W-1:0] mem [STAT_DEPTH];
    logic [STAT_COUNT_W-1:0] mem_rd_q;

    logic [STAT_COUNT_W-1:0] base_val;
    logic [STAT_COUNT_W-1:0] wr_data;
    logic                    wr_en;
    wb_t                     wb_q;

    // ============================
    // mode FSM
    // ============================

    // one counter is cleared per cycle, so the sweep lasts STAT_DEPTH cycles
    always_ff @(posedge clk_125mhz or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= ST_CLEAR;
            clr_cnt_q <= '0;
        end else begin
            case (state_q)
                ST_CLEAR: begin
                    clr_cnt_q <= clr_cnt_q + 1'b1;
                    if (clr_cnt_q == STAT_ID_W'(STAT_DEPTH - 1)) begin
                        state_q <= ST_RUN;
                    end
                end
                default: begin
                    state_q <= ST_RUN;
                end
            endcase
        end
    end

    assign init_busy_o = (state_q == ST_CLEAR);

    // ============================
    // issue stage
    // ============================

    // a host read takes the slot and holds off the increment stream for that cycle
    always_comb begin
        issue_op.op  = OP_IDLE;
        issue_op.id  = s_stat_i.id;
        issue_op.inc = s_stat_i.inc;
        case (state_q)
            ST_CLEAR: begin
                issue_op.op  = OP_CLEAR;
                issue_op.id  = clr_cnt_q;
                issue_op.inc = '0;
            end
            default: begin
                if (rd_req_i) begin
                    issue_op.op = OP_READ;
                    issue_op.id = rd_id_i;
                end else if (s_stat_i.valid) begin
                    issue_op.op = OP_UPDATE;
                end
            end
        endcase
    end

    assign s_ready_o = (state_q == ST_RUN) && !rd_req_i;

    // ============================
    // pipeline registers
    // ============================

    always_ff @(posedge clk_125mhz or negedge rst_n_i) begin
        if (!rst_n_i) begin
            op1_q <= '0;
            op2_q <= '0;
            wb_q  <= '0;
        end else begin
            op1_q   <= issue_op;
            op2_q   <= op1_q;
            wb_q.vld  <= wr_en;
            wb_q.id   <= op2_q.id;
            wb_q.data <= wr_data;
        end
    end

    // stage 1 reads the counter, the write of stage 2 lands on the same edge
    always_ff @(posedge clk_125mhz) begin
        if (wr_en) begin
            mem[op2_q.id] <= wr_data;
        end
        mem_rd_q <= mem[op1_q.id];
    end

    // ============================
    // stage 2
    // ============================

    // the memory read of stage 1 misses a write made on the same edge,
    // so an operation right behind a write to the same id takes that result
    assign base_val = (wb_q.vld && (wb_q.id == op2_q.id)) ? wb_q.data : mem_rd_q;

    always_comb begin
        wr_en   = 1'b0;
        wr_data = base_val;
        case (op2_q.op)
            OP_UPDATE: begin
                wr_en   = 1'b1;
                wr_data = base_val + STAT_COUNT_W'(op2_q.inc);
            end
            OP_CLEAR: begin
                wr_en   = 1'b1;
                wr_data = '0;
            end
            default: begin
                wr_en = 1'b0;
            end
        endcase
    end

    // read response two cycles after the request
    assign rd_valid_o = (op2_q.op == OP_READ);
    assign rd_data_o  = base_val;

endmodule

// ==== src/stat_agg_top.sv ====
// statistics aggregation top level joining the source arbiter to the counter accumulator

`timescale 1ns/1ps

module stat_agg_top
    import stat_cfg_pkg::*;
    import stat_types_pkg::*;
#(
    parameter int PORT_CNT = DEF_PORT_CNT
)
(
    input  logic                    clk_125mhz,
    input  logic                    rst_n_i,

    // increment sources
    input  stat_inc_t               s_stat_i [PORT_CNT],
    output logic [PORT_CNT-1:0]     s_stat_ready_o,

    // host read port
    input  logic                    rd_req_i,
    input  logic [STAT_ID_W-1:0]    rd_id_i,
    output logic                    rd_valid_o,
    output logic [STAT_COUNT_W-1:0] rd_data_o,

    output logic                    init_busy_o
);

    // ============================
    // arbiter to accumulator
    // ============================

    stat_inc_t mux_stat;
    logic      accum_ready;

    stat_arb_mux #(
        .PORT_CNT(PORT_CNT)
    ) u_arb_mux (
        .clk_125mhz    (clk_125mhz),
        .rst_n_i       (rst_n_i),
        .s_stat_i      (s_stat_i),
        .s_stat_ready_o(s_stat_ready_o),
        .m_stat_o      (mux_stat),
        .m_ready_i     (accum_ready)
    );

    stat_accum u_accum (
        .clk_125mhz (clk_125mhz),
        .rst_n_i    (rst_n_i),
        .s_stat_i   (mux_stat),
        .s_ready_o  (accum_ready),
        .rd_req_i   (rd_req_i),
        .rd_id_i    (rd_id_i),
        .rd_valid_o (rd_valid_o),
        .rd_data_o  (rd_data_o),
        .init_busy_o(init_busy_o)
    );

endmodule

// ==== tb/stat_agg_asserts.sv ====
// timing rules of the statistics aggregation top level checked by concurrent assertions

`timescale 1ns/1ps

module stat_agg_asserts #(
    parameter int PORT_CNT = 4
)
(
    input logic                clk_125mhz,
    input logic                rst_n_i,
    input logic [PORT_CNT-1:0] s_stat_ready_o,
    input logic                rd_req_i,
    input logic                rd_valid_o,
    input logic                init_busy_o
);

    // ============================
    // read port
    // ============================

    a_rd_latency: assert property (@(posedge clk_125mhz) disable iff (!rst_n_i)
        rd_valid_o == $past(rd_req_i, 2))
        else $error("rd_valid_o does not follow rd_req_i by 2 cycles");

    // ============================
    // source grants
    // ============================

    a_ready_onehot: assert property (@(posedge clk_125mhz) disable iff (!rst_n_i)
        $onehot0(s_stat_ready_o))
        else $error("more than one source ready in one cycle");

    a_ready_in_clear: assert property (@(posedge clk_125mhz) disable iff (!rst_n_i)
        init_busy_o |-> (s_stat_ready_o == '0))
        else $error("source ready during the clear sweep");

    a_busy_stays_low: assert property (@(posedge clk_125mhz) disable iff (!rst_n_i)
        !init_busy_o |=> !init_busy_o)
        else $error("init_busy_o rose again");

endmodule

bind stat_agg_top stat_agg_asserts #(.PORT_CNT(PORT_CNT)) u_asserts (
    .clk_125mhz    (clk_125mhz),
    .rst_n_i       (rst_n_i),
    .s_stat_ready_o(s_stat_ready_o),
    .rd_req_i      (rd_req_i),
    .rd_valid_o    (rd_valid_o),
    .init_busy_o   (init_busy_o)
);

// ==== tb/tb_stat_agg.sv ====
// testbench for the statistics aggregation pipeline with a table of increments and a sum model

`timescale 1ns/1ps

module tb_stat_agg
    import stat_cfg_pkg::*;
    import stat_types_pkg::*;
;

    localparam int NSRC = 4;

    logic                    clk_125mhz;
    logic                    rst_n_i;
    stat_inc_t               s_stat [NSRC];
    logic [NSRC-1:0]         s_stat_ready;
    logic                    rd_req;
    logic [STAT_ID_W-1:0]    rd_id;
    logic                    rd_valid;
    logic [STAT_COUNT_W-1:0] rd_data;
    logic                    init_busy;

    // stimulus table: source, counter id, increment
    int q_src[$];
    int q_id[$];
    int q_inc[$];

    // reference model and handshake log
    logic [STAT_COUNT_W-1:0] model [STAT_DEPTH];
    time log_t[$];
    int  log_id[$];
    int  log_inc[$];
    bit  fair_chk;
    int  since_cnt [NSRC];

    stat_agg_top #(.PORT_CNT(NSRC)) u_dut (
        .clk_125mhz    (clk_125mhz),
        .rst_n_i       (rst_n_i),
        .s_stat_i      (s_stat),
        .s_stat_ready_o(s_stat_ready),
        .rd_req_i      (rd_req),
        .rd_id_i       (rd_id),
        .rd_valid_o    (rd_valid),
        .rd_data_o     (rd_data),
        .init_busy_o   (init_busy)
    );

    initial begin
        clk_125mhz = 1'b0;
        forever #5 clk_125mhz = ~clk_125mhz;
    end

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input longint unsigned exp_v,
                                   input longint unsigned act_v);
        $display("error at %0t: %s expected %0d, got %0d", $time, sig, exp_v, act_v);
        stop_with_failure("value check failed");
    endtask

    // every transfer at a source is added to the model when it happens
    always @(posedge clk_125mhz) begin
        for (int i = 0; i < NSRC; i++) begin
            if (rst_n_i && s_stat[i].valid && s_stat_ready[i]) begin
                model[s_stat[i].id] += STAT_COUNT_W'(s_stat[i].inc);
                log_t.push_back($time);
                log_id.push_back(int'(s_stat[i].id));
                log_inc.push_back(int'(s_stat[i].inc));
                if (fair_chk) begin
                    for (int j = 0; j < NSRC; j++) begin
                        since_cnt[j] = (j == i) ? 0 : since_cnt[j] + 1;
                        assert (since_cnt[j] < NSRC) else
                            stop_with_failure("a source went 4 transfers without a grant");
                    end
                end
            end
        end
    end

    function automatic int next_entry(input int src, input int from);
        for (int k = from; k < q_src.size(); k++) begin
            if (q_src[k] == src) return k;
        end
        return -1;
    endfunction

    // one process drives all sources, each taking its own table rows in order
    task automatic run_sources(input bit back_to_back);
        int        ptr [NSRC];
        int        gap [NSRC];
        int        wait_cnt [NSRC];
        bit        done;
        stat_inc_t m;

        for (int i = 0; i < NSRC; i++) begin
            ptr[i] = next_entry(i, 0);
            gap[i] = 0;
            wait_cnt[i] = 0;
        end
        forever begin
            done = 1'b1;
            for (int i = 0; i < NSRC; i++) begin
                if (s_stat[i].valid || ptr[i] >= 0) done = 1'b0;
            end
            if (done) break;
            @(posedge clk_125mhz);
            for (int i = 0; i < NSRC; i++) begin
                if (s_stat[i].valid && !s_stat_ready[i]) begin
                    wait_cnt[i]++;
                    assert (wait_cnt[i] < 200) else
                        stop_with_failure("timeout waiting for s_stat_ready_o");
                end else begin
                    if (s_stat[i].valid) begin
                        wait_cnt[i] = 0;
                        gap[i] = back_to_back ? 0 : int'($urandom_range(0, 3));
                    end
                    if (ptr[i] >= 0 && gap[i] == 0) begin
                        m.valid = 1'b1;
                        m.id    = STAT_ID_W'(q_id[ptr[i]]);
                        m.inc   = STAT_INC_W'(q_inc[ptr[i]]);
                        s_stat[i] <= m;
                        ptr[i] = next_entry(i, ptr[i] + 1);
                    end else begin
                        s_stat[i] <= '0;
                        if (gap[i] > 0) gap[i]--;
                    end
                end
            end
        end
        q_src.delete();
        q_id.delete();
        q_inc.delete();
    endtask

    task automatic do_read(input int id, output logic [STAT_COUNT_W-1:0] data,
                           output time t_req);
        int n;

        @(posedge clk_125mhz);
        rd_req <= 1'b1;
        rd_id  <= STAT_ID_W'(id);
        t_req = $time;
        @(posedge clk_125mhz);
        rd_req <= 1'b0;
        n = 0;
        do begin
            @(posedge clk_125mhz);
            n++;
            assert (n < 10) else stop_with_failure("timeout waiting for rd_valid_o");
        end while (!rd_valid);
        assert (n == 2) else report_mismatch("rd_valid_o delay", 2, n);
        data = rd_data;
    endtask

    // read during traffic and bound the value by the logged transfers
    task automatic read_in_traffic(input int id);
        logic [STAT_COUNT_W-1:0] val;
        time                     t_req;
        longint unsigned         lo;
        longint unsigned         hi;

        do_read(id, val, t_req);
        lo = 0;
        hi = 0;
        for (int k = 0; k < log_t.size(); k++) begin
            if (log_id[k] == id && log_t[k] <= t_req - 20) lo += log_inc[k];
            if (log_id[k] == id && log_t[k] <= t_req + 10) hi += log_inc[k];
        end
        assert (val >= lo && val <= hi) else begin
            $display("error at %0t: rd_data_o expected %0d..%0d, got %0d", $time, lo, hi, val);
            stop_with_failure("read value outside the accepted range");
        end
    endtask

    int tbl_src [16] = '{0, 1, 2, 3, 0, 1, 2, 3, 0, 1, 2, 3, 0, 1, 2, 3};
    int tbl_id  [16] = '{10, 10, 11, 12, 11, 2047, 10, 0, 12, 11, 0, 10, 2047, 12, 11, 10};
    int tbl_inc [16] = '{5, 7, 65535, 1, 300, 9, 12, 4, 65535, 8, 21, 3, 2, 100, 6, 40000};

    initial begin
        logic [STAT_COUNT_W-1:0] val;
        time                     t_req;
        longint unsigned         exp_sum;
        int                      n;

        void'($urandom(32'ha4bb));
        for (int i = 0; i < STAT_DEPTH; i++) model[i] = '0;
        for (int i = 0; i < NSRC; i++) begin
            s_stat[i] = '0;
            since_cnt[i] = 0;
        end
        fair_chk = 1'b0;
        rd_req   = 1'b0;
        rd_id    = '0;
        rst_n_i  = 1'b0;
        repeat (5) @(posedge clk_125mhz);

        // outputs while reset is held
        assert (init_busy == 1'b1) else report_mismatch("init_busy_o", 1, init_busy);
        assert (rd_valid == 1'b0) else report_mismatch("rd_valid_o", 0, rd_valid);
        assert (s_stat_ready == '0) else
            report_mismatch("s_stat_ready_o", 0, s_stat_ready);
        rst_n_i <= 1'b1;

        // clear sweep ends, then every counter reads zero
        n = 0;
        while (init_busy) begin
            @(posedge clk_125mhz);
            n++;
            assert (n < STAT_DEPTH + 50) else stop_with_failure("init_busy_o never fell");
        end
        foreach (tbl_id[k]) begin
            do_read(tbl_id[k], val, t_req);
            assert (val == 0) else report_mismatch("rd_data_o", 0, val);
        end

        // table traffic from all sources with random gaps
        foreach (tbl_src[k]) begin
            q_src.push_back(tbl_src[k]);
            q_id.push_back(tbl_id[k]);
            q_inc.push_back(tbl_inc[k]);
        end
        run_sources(1'b0);
        repeat (3) @(posedge clk_125mhz);
        foreach (tbl_id[k]) begin
            do_read(tbl_id[k], val, t_req);
            assert (val == model[tbl_id[k]]) else
                report_mismatch("rd_data_o", model[tbl_id[k]], val);
        end

        // back-to-back updates of one id from one source
        exp_sum = 0;
        for (int k = 0; k < 20; k++) begin
            q_src.push_back(1);
            q_id.push_back(77);
            q_inc.push_back((k + 1) * 100);
            exp_sum += (k + 1) * 100;
        end
        run_sources(1'b1);
        repeat (3) @(posedge clk_125mhz);
        do_read(77, val, t_req);
        assert (val == exp_sum) else report_mismatch("rd_data_o", exp_sum, val);

        // all sources busy for fairness, with host reads in the middle
        for (int k = 0; k < 12 * NSRC; k++) begin
            q_src.push_back(k % NSRC);
            q_id.push_back(300 + (k % 2));
            q_inc.push_back(1000 + k);
        end
        fair_chk = 1'b1;
        fork
            run_sources(1'b1);
            for (int r = 0; r < 6; r++) begin
                repeat (4) @(posedge clk_125mhz);
                read_in_traffic(300 + (r % 2));
            end
        join
        fair_chk = 1'b0;
        repeat (3) @(posedge clk_125mhz);
        do_read(300, val, t_req);
        assert (val == model[300]) else report_mismatch("rd_data_o", model[300], val);

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== verilog.f ====
common/stat_cfg_pkg.sv
common/stat_types_pkg.sv
stat/stat_arb_mux.sv
stat/stat_accum.sv
src/stat_agg_top.sv
tb/stat_agg_asserts.sv
tb/tb_stat_agg.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the statistics aggregation testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_stat_agg \
    -f verilog.f \
    -Mdir obj_dir

./obj_dir/Vtb_stat_agg
